/* ddr3_pkg.sv */
package ddr3_pkg;

   localparam int DQ_BITS    = 16;
   localparam int BA_BITS    = 3;
   localparam int ROW_BITS   = 13;
   localparam int COL_BITS   = 10;
   localparam int ADDR_BITS  = 14;
   localparam int BURST_LEN  = 8;
   localparam int BURST_BITS = BURST_LEN * DQ_BITS;
   localparam int HOST_BITS  = BA_BITS + ROW_BITS + COL_BITS;

   typedef logic [BA_BITS-1:0]    bank_t;
   typedef logic [ROW_BITS-1:0]   row_t;
   typedef logic [COL_BITS-1:0]   col_t;
   typedef logic [ADDR_BITS-1:0]  pin_addr_t;

   // Bank above row above column
   typedef logic [HOST_BITS-1:0]  host_addr_t;

   // Beat 0 in the low bits
   typedef logic [BURST_BITS-1:0] burst_t;

   typedef logic [15:0]           cycles_t;

   typedef enum logic [2:0] {
      CMD_NOP,
      CMD_MRS,
      CMD_REF,
      CMD_PRE,
      CMD_ACT,
      CMD_WR,
      CMD_RD,
      CMD_ZQCL
   } ddr3_cmd_e;

   typedef struct packed {
      ddr3_cmd_e cmd;
      bank_t     ba;
      pin_addr_t addr;
   } dram_cmd_t;

   localparam dram_cmd_t NOP_CMD = '{cmd: CMD_NOP, ba: '0, addr: '0};

   // DLL on, RZQ/4 termination, no additive latency
   localparam pin_addr_t MR1_VALUE = 14'h0004;

endpackage

/* ddr3_init_seq.sv */
module ddr3_init_seq #(
   parameter int T_PWR    = 16,
   parameter int T_XPR    = 48,
   parameter int T_ZQINIT = 512,
   parameter int T_MRD    = 4,
   parameter int T_MOD    = 12,
   parameter int CL       = 6,
   parameter int CWL      = 5,
   parameter int T_WR     = 6
) (
   input  logic                clk_400M,
   input  logic                rst_i,
   output ddr3_pkg::dram_cmd_t init_cmd_o,
   output logic                init_done_o,
   output logic                mem_rst_n_o,
   output logic                cke_o
);
   import ddr3_pkg::*;

   typedef enum logic [3:0] {
      POWERUP, WAIT_XPR, ZQCL, MRS3, MRS2, MRS1, MRS0, WAIT_MOD, DONE
   } state_e;

   localparam pin_addr_t MR2_WORD = pin_addr_t'((CWL - 5) << 3);
   // Write recovery, DLL reset, CAS latency, BL8
   localparam pin_addr_t MR0_WORD =
      pin_addr_t'(((T_WR - 4) << 9) | (1 << 8) | ((CL - 4) << 4));

   state_e  state_q, state_d;
   cycles_t cnt_q;
   cycles_t wait_len;
   logic    last;

   always_comb begin
      case (state_q)
         POWERUP:          wait_len = cycles_t'(T_PWR);
         WAIT_XPR:         wait_len = cycles_t'(T_XPR - 1); // ZQCL reaches pins a cycle later
         ZQCL:             wait_len = cycles_t'(T_ZQINIT);
         MRS3, MRS2, MRS1: wait_len = cycles_t'(T_MRD);
         WAIT_MOD:         wait_len = cycles_t'(T_MOD - 1);
         default:          wait_len = cycles_t'(1);
      endcase
   end

   assign last = (cnt_q == wait_len - 1'b1);

   always_comb begin
      state_d = state_q;
      if (last) begin
         case (state_q)
            POWERUP:  state_d = mem_rst_n_o ? WAIT_XPR : POWERUP; // Second half gates cke
            WAIT_XPR: state_d = ZQCL;
            ZQCL:     state_d = MRS3;
            MRS3:     state_d = MRS2;
            MRS2:     state_d = MRS1;
            MRS1:     state_d = MRS0;
            MRS0:     state_d = WAIT_MOD;
            WAIT_MOD: state_d = DONE;
            default:  state_d = DONE;
         endcase
      end
   end

   // Each command goes out in the first cycle of its state
   always_comb begin
      init_cmd_o = NOP_CMD;
      if (cnt_q == '0) begin
         case (state_q)
            ZQCL: init_cmd_o = '{cmd: CMD_ZQCL, ba: bank_t'(0), addr: pin_addr_t'(1) << 10};
            MRS3: init_cmd_o = '{cmd: CMD_MRS, ba: bank_t'(3), addr: '0};
            MRS2: init_cmd_o = '{cmd: CMD_MRS, ba: bank_t'(2), addr: MR2_WORD};
            MRS1: init_cmd_o = '{cmd: CMD_MRS, ba: bank_t'(1), addr: MR1_VALUE};
            MRS0: init_cmd_o = '{cmd: CMD_MRS, ba: bank_t'(0), addr: MR0_WORD};
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk_400M) begin
      if (rst_i) begin
         state_q     <= POWERUP;
         cnt_q       <= '0;
         mem_rst_n_o <= 1'b0;
         cke_o       <= 1'b0;
      end else begin
         state_q <= state_d;
         cnt_q   <= last ? '0 : cnt_q + 1'b1;
         if (state_q == POWERUP && last) begin
            mem_rst_n_o <= 1'b1;
            cke_o       <= mem_rst_n_o;
         end
      end
   end

   assign init_done_o = (state_q == DONE);

   a_init_done_sticky: assert property (@(posedge clk_400M) disable iff (rst_i)
      init_done_o |=> init_done_o);

endmodule

/* ddr3_access_fsm.sv */
module ddr3_access_fsm #(
   parameter int T_RCD  = 6,
   parameter int T_WR   = 6,
   parameter int T_RP   = 6,
   parameter int T_RFC  = 44,
   parameter int T_REFI = 3120
) (
   input  logic                 clk_400M,
   input  logic                 rst_i,
   input  logic                 init_done_i,
   input  logic                 read_i,
   input  logic                 write_i,
   input  ddr3_pkg::host_addr_t address_i,
   input  ddr3_pkg::burst_t     write_data_i,
   input  logic                 wr_done_i,
   input  logic                 rd_done_i,
   output logic                 wr_load_o,
   output ddr3_pkg::burst_t     wr_data_o,
   output logic                 wr_start_o,
   output logic                 rd_start_o,
   output ddr3_pkg::dram_cmd_t  acc_cmd_o,
   output logic                 odt_o,
   output logic                 busy_o,
   output logic                 ack_o
);
   import ddr3_pkg::*;

   typedef enum logic [3:0] {
      IDLE, ACT, WAIT_RCD, WR, WAIT_WDATA, WAIT_WR,
      RD, WAIT_RDATA, PRE, WAIT_RP, REF, WAIT_RFC
   } state_e;

   state_e  state_q, state_d;
   cycles_t cnt_q;
   cycles_t wait_len;
   cycles_t ref_cnt_q;
   logic    last;
   logic    ref_due;
   logic    accept;
   logic    wr_op_q;
   logic    odt_q;
   bank_t   bank_q;
   row_t    row_q;
   col_t    col_q;

   assign ref_due   = (ref_cnt_q == '0);
   assign busy_o    = !(state_q == IDLE && init_done_i && !ref_due);
   assign accept    = !busy_o && (write_i || read_i);
   assign wr_load_o = accept && write_i; // Write wins over read
   assign wr_data_o = write_data_i;
   assign wr_start_o = (state_q == WR);
   assign rd_start_o = (state_q == RD);
   assign ack_o     = (state_q == PRE);
   assign odt_o     = odt_q;

   always_comb begin
      case (state_q)
         WAIT_RCD: wait_len = cycles_t'(T_RCD - 1);
         WAIT_WR:  wait_len = cycles_t'(T_WR - 1);
         WAIT_RP:  wait_len = cycles_t'(T_RP - 1);
         WAIT_RFC: wait_len = cycles_t'(T_RFC - 1);
         default:  wait_len = cycles_t'(1);
      endcase
   end

   assign last = (cnt_q == wait_len - 1'b1);

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (init_done_i && ref_due) state_d = REF;
            else if (accept)            state_d = ACT;
         end
         ACT:        state_d = WAIT_RCD;
         WAIT_RCD:   if (last) state_d = wr_op_q ? WR : RD;
         WR:         state_d = WAIT_WDATA;
         WAIT_WDATA: if (wr_done_i) state_d = WAIT_WR;
         WAIT_WR:    if (last) state_d = PRE;
         RD:         state_d = WAIT_RDATA;
         WAIT_RDATA: if (rd_done_i) state_d = PRE;
         PRE:        state_d = WAIT_RP;
         WAIT_RP:    if (last) state_d = IDLE;
         REF:        state_d = WAIT_RFC;
         WAIT_RFC:   if (last) state_d = IDLE;
         default:    state_d = IDLE;
      endcase
   end

   always_comb begin
      acc_cmd_o = NOP_CMD;
      case (state_q)
         ACT: acc_cmd_o = '{cmd: CMD_ACT, ba: bank_q, addr: pin_addr_t'(row_q)};
         WR:  acc_cmd_o = '{cmd: CMD_WR, ba: bank_q, addr: pin_addr_t'(col_q)};
         RD:  acc_cmd_o = '{cmd: CMD_RD, ba: bank_q, addr: pin_addr_t'(col_q)};
         PRE: acc_cmd_o = '{cmd: CMD_PRE, ba: bank_q, addr: '0}; // A10 low, one bank
         REF: acc_cmd_o = '{cmd: CMD_REF, ba: '0, addr: '0};
         default: ;
      endcase
   end

   always_ff @(posedge clk_400M) begin
      if (rst_i) begin
         state_q   <= IDLE;
         cnt_q     <= '0;
         ref_cnt_q <= '0; // First command after init is REF
         wr_op_q   <= 1'b0;
         odt_q     <= 1'b0;
      end else begin
         state_q <= state_d;
         cnt_q   <= last ? '0 : cnt_q + 1'b1;
         if (state_q == REF) begin
            ref_cnt_q <= cycles_t'(T_REFI);
         end else if (!ref_due) begin
            ref_cnt_q <= ref_cnt_q - 1'b1;
         end
         if (accept) begin
            wr_op_q <= write_i;
            odt_q   <= write_i;
         end else if (state_q == PRE) begin
            odt_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_400M) begin
      if (accept) begin
         {bank_q, row_q, col_q} <= address_i;
      end
   end

   a_idle_until_init: assert property (@(posedge clk_400M) disable iff (rst_i)
      (state_q != IDLE) |-> init_done_i);

   a_ack_single: assert property (@(posedge clk_400M) disable iff (rst_i)
      ack_o |=> !ack_o);

endmodule

/* ddr3_cmd_encoder.sv */
module ddr3_cmd_encoder (
   input  logic                 clk_400M,
   input  logic                 rst_i,
   input  ddr3_pkg::dram_cmd_t  init_cmd_i,
   input  ddr3_pkg::dram_cmd_t  acc_cmd_i,
   output logic                 cs_n_o,
   output logic                 ras_n_o,
   output logic                 cas_n_o,
   output logic                 we_n_o,
   output ddr3_pkg::bank_t      ba_o,
   output ddr3_pkg::pin_addr_t  a_o
);
   import ddr3_pkg::*;

   dram_cmd_t  sel;
   logic [3:0] strobes; // cs_n, ras_n, cas_n, we_n

   assign sel = (init_cmd_i.cmd != CMD_NOP) ? init_cmd_i : acc_cmd_i;

   always_comb begin
      case (sel.cmd)
         CMD_MRS:  strobes = 4'b0000;
         CMD_REF:  strobes = 4'b0001;
         CMD_PRE:  strobes = 4'b0010;
         CMD_ACT:  strobes = 4'b0011;
         CMD_WR:   strobes = 4'b0100;
         CMD_RD:   strobes = 4'b0101;
         CMD_ZQCL: strobes = 4'b0110;
         default:  strobes = 4'b0111; // NOP
      endcase
   end

   always_ff @(posedge clk_400M) begin
      if (rst_i) begin
         {cs_n_o, ras_n_o, cas_n_o, we_n_o} <= 4'b1111;
         ba_o <= '0;
         a_o  <= '0;
      end else begin
         {cs_n_o, ras_n_o, cas_n_o, we_n_o} <= strobes;
         ba_o <= sel.ba;
         a_o  <= sel.addr;
      end
   end

   a_one_source: assert property (@(posedge clk_400M) disable iff (rst_i)
      !(init_cmd_i.cmd != CMD_NOP && acc_cmd_i.cmd != CMD_NOP));

endmodule

/* ddr3_write_path.sv */
module ddr3_write_path #(
   parameter int CWL = 5
) (
   input  logic                          clk_400M,
   input  logic                          rst_i,
   input  logic                          wr_load_i,
   input  ddr3_pkg::burst_t              wr_data_i,
   input  logic                          wr_start_i,
   output logic [ddr3_pkg::DQ_BITS-1:0]  dq_o,
   output logic                          dq_oe_o,
   output logic                          wr_done_o
);
   import ddr3_pkg::*;

   localparam int BEAT_W = $clog2(BURST_LEN);
   localparam logic [BEAT_W-1:0] BEAT_LAST = BEAT_W'(BURST_LEN - 1);

   burst_t              data_q;
   cycles_t             lat_q;
   logic [BEAT_W-1:0]   beat_q;
   logic                emit;

   // Latency counts from the struct, the pins lag by one register
   assign emit = (lat_q == cycles_t'(1)) || (dq_oe_o && beat_q != BEAT_LAST);

   always_ff @(posedge clk_400M) begin
      if (rst_i) begin
         lat_q     <= '0;
         beat_q    <= '0;
         dq_oe_o   <= 1'b0;
         wr_done_o <= 1'b0;
      end else begin
         if (wr_start_i) begin
            lat_q <= cycles_t'(CWL);
         end else if (lat_q != '0) begin
            lat_q <= lat_q - 1'b1;
         end
         dq_oe_o   <= emit;
         beat_q    <= dq_oe_o ? beat_q + 1'b1 : '0;
         wr_done_o <= dq_oe_o && beat_q == BEAT_LAST;
      end
   end

   always_ff @(posedge clk_400M) begin
      if (wr_load_i) begin
         data_q <= wr_data_i;
      end else if (emit) begin
         data_q <= data_q >> DQ_BITS;
      end
      if (emit) begin
         dq_o <= data_q[DQ_BITS-1:0];
      end
   end

   a_wr_window: assert property (@(posedge clk_400M) disable iff (rst_i)
      wr_start_i |-> ##(CWL + 1) dq_oe_o [*BURST_LEN] ##1 !dq_oe_o);

endmodule

/* ddr3_read_path.sv */
module ddr3_read_path #(
   parameter int CL = 6
) (
   input  logic                          clk_400M,
   input  logic                          rst_i,
   input  logic                          rd_start_i,
   input  logic [ddr3_pkg::DQ_BITS-1:0]  dq_i,
   output ddr3_pkg::burst_t              read_data_o,
   output logic                          rd_done_o
);
   import ddr3_pkg::*;

   localparam int BEAT_W = $clog2(BURST_LEN);
   localparam logic [BEAT_W-1:0] BEAT_LAST = BEAT_W'(BURST_LEN - 1);

   burst_t              sh_q;
   cycles_t             lat_q;
   logic [BEAT_W-1:0]   beat_q;
   logic                cap_q;
   logic                last_beat;

   assign last_beat = cap_q && (beat_q == BEAT_LAST);

   always_ff @(posedge clk_400M) begin
      if (rst_i) begin
         lat_q     <= '0;
         beat_q    <= '0;
         cap_q     <= 1'b0;
         rd_done_o <= 1'b0;
      end else begin
         if (rd_start_i) begin
            lat_q <= cycles_t'(CL);
         end else if (lat_q != '0) begin
            lat_q <= lat_q - 1'b1;
         end
         if (lat_q == cycles_t'(1)) begin
            cap_q  <= 1'b1;
            beat_q <= '0;
         end else if (last_beat) begin
            cap_q <= 1'b0;
         end else if (cap_q) begin
            beat_q <= beat_q + 1'b1;
         end
         rd_done_o <= last_beat;
      end
   end

   // New beats enter at the top, beat 0 ends in the low bits
   always_ff @(posedge clk_400M) begin
      if (cap_q) begin
         sh_q <= {dq_i, sh_q[BURST_BITS-1:DQ_BITS]};
      end
      if (last_beat) begin
         read_data_o <= {dq_i, sh_q[BURST_BITS-1:DQ_BITS]};
      end
   end

   a_no_overlap: assert property (@(posedge clk_400M) disable iff (rst_i)
      (cap_q || lat_q != '0) |-> !rd_start_i);

endmodule

/* ddr3_ctrl_top.sv */
module ddr3_ctrl_top #(
   parameter int CL       = 6,
   parameter int CWL      = 5,
   parameter int T_RCD    = 6,
   parameter int T_RP     = 6,
   parameter int T_WR     = 6,
   parameter int T_MRD    = 4,
   parameter int T_MOD    = 12,
   parameter int T_RFC    = 44,
   parameter int T_XPR    = 48,
   parameter int T_ZQINIT = 512,
   parameter int T_PWR    = 16,
   parameter int T_REFI   = 3120
) (
   input  logic                          clk_400M,
   input  logic                          rst_i,
   input  logic                          read_i,
   input  logic                          write_i,
   input  ddr3_pkg::host_addr_t          address_i,
   input  ddr3_pkg::burst_t              write_data_i,
   output ddr3_pkg::burst_t              read_data_o,
   output logic                          ack_o,
   output logic                          busy_o,
   output logic                          mem_rst_n_o,
   output logic                          cke_o,
   output logic                          cs_n_o,
   output logic                          ras_n_o,
   output logic                          cas_n_o,
   output logic                          we_n_o,
   output ddr3_pkg::bank_t               ba_o,
   output ddr3_pkg::pin_addr_t           a_o,
   output logic                          odt_o,
   output logic [ddr3_pkg::DQ_BITS-1:0]  dq_o,
   output logic                          dq_oe_o,
   input  logic [ddr3_pkg::DQ_BITS-1:0]  dq_i
);
   import ddr3_pkg::*;

   dram_cmd_t init_cmd, acc_cmd;
   burst_t    wr_data;
   logic      init_done;
   logic      wr_load, wr_start, wr_done;
   logic      rd_start, rd_done;

   ddr3_init_seq #(
      .T_PWR(T_PWR), .T_XPR(T_XPR), .T_ZQINIT(T_ZQINIT), .T_MRD(T_MRD),
      .T_MOD(T_MOD), .CL(CL), .CWL(CWL), .T_WR(T_WR)
   ) u_init (
      .clk_400M, .rst_i,
      .init_cmd_o(init_cmd), .init_done_o(init_done),
      .mem_rst_n_o, .cke_o
   );

   ddr3_access_fsm #(
      .T_RCD(T_RCD), .T_WR(T_WR), .T_RP(T_RP), .T_RFC(T_RFC), .T_REFI(T_REFI)
   ) u_access (
      .clk_400M, .rst_i, .init_done_i(init_done),
      .read_i, .write_i, .address_i, .write_data_i,
      .wr_done_i(wr_done), .rd_done_i(rd_done),
      .wr_load_o(wr_load), .wr_data_o(wr_data),
      .wr_start_o(wr_start), .rd_start_o(rd_start),
      .acc_cmd_o(acc_cmd), .odt_o, .busy_o, .ack_o
   );

   ddr3_cmd_encoder u_enc (
      .clk_400M, .rst_i, .init_cmd_i(init_cmd), .acc_cmd_i(acc_cmd),
      .cs_n_o, .ras_n_o, .cas_n_o, .we_n_o, .ba_o, .a_o
   );

   ddr3_write_path #(.CWL(CWL)) u_wr (
      .clk_400M, .rst_i, .wr_load_i(wr_load), .wr_data_i(wr_data),
      .wr_start_i(wr_start), .dq_o, .dq_oe_o, .wr_done_o(wr_done)
   );

   ddr3_read_path #(.CL(CL)) u_rd (
      .clk_400M, .rst_i, .rd_start_i(rd_start), .dq_i,
      .read_data_o, .rd_done_o(rd_done)
   );

endmodule

/* tb_ddr3_model.sv */
module tb_ddr3_model #(
   parameter int CL      = 6,
   parameter int CWL     = 5,
   parameter int T_RCD   = 6,
   parameter int T_RP    = 6,
   parameter int T_WR    = 6,
   parameter int T_RFC   = 44,
   parameter int T_REFI  = 300,
   parameter int ACC_LEN = 45
) (
   input  logic                          clk_400M,
   input  logic                          rst_i,
   input  logic                          mem_rst_n_i,
   input  logic                          cke_i,
   input  logic                          cs_n_i,
   input  logic                          ras_n_i,
   input  logic                          cas_n_i,
   input  logic                          we_n_i,
   input  ddr3_pkg::bank_t               ba_i,
   input  ddr3_pkg::pin_addr_t           a_i,
   input  logic [ddr3_pkg::DQ_BITS-1:0]  dq_i,
   input  logic                          dq_oe_i,
   output logic [ddr3_pkg::DQ_BITS-1:0]  dq_o,
   output logic                          init_ok_o,
   output logic                          err_o
);
   timeunit 1ns;
   timeprecision 1ps;
   import ddr3_pkg::*;

   localparam logic [2:0] C_MRS = 3'b000;
   localparam logic [2:0] C_REF = 3'b001;
   localparam logic [2:0] C_PRE = 3'b010;
   localparam logic [2:0] C_ACT = 3'b011;
   localparam logic [2:0] C_WR  = 3'b100;
   localparam logic [2:0] C_RD  = 3'b101;
   localparam logic [2:0] C_ZQ  = 3'b110;

   logic [2:0]  cmd, exp_cmd;
   bank_t       exp_ba;
   logic        is_cmd, in_wr_win;
   int          cyc = 0;
   int          act_cyc = -100000;
   int          pre_cyc = -100000;
   int          ref_cyc = -100000;
   int          wr_base, rd_base, wr_off, rd_off, ref_gap, ref_hi;
   int          init_step = 0;
   logic        ref_seen = 1'b0;
   logic        act_since_ref = 1'b0;
   logic        wr_act = 1'b0;
   logic        rd_act = 1'b0;
   logic        rst_n_q = 1'b0; // mem_rst_n one cycle back
   row_t        open_row [8];
   burst_t      mem [host_addr_t];
   burst_t      wr_buf, rd_buf;
   host_addr_t  wr_key;
   logic [DQ_BITS-1:0] dq_q = '0;
   logic        ok_init, ok_mr2, ok_mr0, ok_cke, ok_rcd, ok_rp, ok_rfc, ok_refi, ok_oe;

   // Unwritten locations read back a pattern of their own address
   function automatic burst_t lookup(input host_addr_t key);
      if (mem.exists(key)) return mem[key];
      return {4{6'b0, key}};
   endfunction

   assign cmd       = {ras_n_i, cas_n_i, we_n_i};
   assign is_cmd    = !cs_n_i && cmd != 3'b111;
   assign wr_off    = cyc - wr_base;
   assign rd_off    = cyc - rd_base;
   assign in_wr_win = wr_act && wr_off >= CWL && wr_off < CWL + BURST_LEN;
   assign init_ok_o = init_step >= 6;
   assign ref_gap   = cyc - ref_cyc;
   assign ref_hi    = act_since_ref ? T_REFI + ACC_LEN : T_REFI + T_RFC + 2;
   assign dq_o      = dq_q;

   always_comb begin
      exp_ba = bank_t'(4 - init_step);
      case (init_step)
         0:          exp_cmd = C_ZQ;
         1, 2, 3, 4: exp_cmd = C_MRS; // MR3 down to MR0
         default:    exp_cmd = C_REF;
      endcase
   end

   assign ok_init = !(is_cmd && init_step < 6) ||
                    (cmd == exp_cmd && (cmd != C_MRS || ba_i == exp_ba));
   assign ok_mr2  = !(is_cmd && init_step == 2) || a_i[5:3] == 3'(CWL - 5);
   assign ok_mr0  = !(is_cmd && init_step == 4) ||
                    (a_i[6:4] == 3'(CL - 4) && !a_i[2] &&
                     a_i[11:9] == 3'(T_WR - 4) && a_i[1:0] == 2'b00);
   assign ok_cke  = (!cke_i || rst_n_q) && (!is_cmd || cke_i);
   assign ok_rcd  = !(is_cmd && (cmd == C_WR || cmd == C_RD)) || cyc - act_cyc >= T_RCD;
   assign ok_rp   = !is_cmd || cyc - pre_cyc >= T_RP;
   assign ok_rfc  = !is_cmd || cyc - ref_cyc >= T_RFC;
   assign ok_refi = !(is_cmd && cmd == C_REF && ref_seen) ||
                    (ref_gap >= T_REFI && ref_gap <= ref_hi);
   assign ok_oe   = dq_oe_i == in_wr_win;

   a_init_order: assert property (@(posedge clk_400M) disable iff (rst_i) ok_init)
      else $display("Init sequence broken: command %b bank %0d at step %0d", cmd, ba_i, init_step);
   a_mr2: assert property (@(posedge clk_400M) disable iff (rst_i) ok_mr2)
      else $display("Mismatch at %0t: MR2 a_o expected CWL field %0d got %h", $time, CWL - 5, a_i);
   a_mr0: assert property (@(posedge clk_400M) disable iff (rst_i) ok_mr0)
      else $display("Mismatch at %0t: MR0 a_o expected CL %0d WR %0d got %h", $time, CL, T_WR, a_i);
   a_cke: assert property (@(posedge clk_400M) disable iff (rst_i) ok_cke)
      else $display("Power-up order broken: cke or a command came before memory reset release");
   a_rcd: assert property (@(posedge clk_400M) disable iff (rst_i) ok_rcd)
      else $display("ACT to column command only %0d cycles", cyc - act_cyc);
   a_rp: assert property (@(posedge clk_400M) disable iff (rst_i) ok_rp)
      else $display("Command only %0d cycles after PRE", cyc - pre_cyc);
   a_rfc: assert property (@(posedge clk_400M) disable iff (rst_i) ok_rfc)
      else $display("Command only %0d cycles after REF", cyc - ref_cyc);
   a_refi: assert property (@(posedge clk_400M) disable iff (rst_i) ok_refi)
      else $display("Refresh interval of %0d cycles outside %0d to %0d", ref_gap, T_REFI, ref_hi);
   a_oe: assert property (@(posedge clk_400M) disable iff (rst_i) ok_oe)
      else $display("Mismatch at %0t: dq_oe_o expected %b got %b", $time, in_wr_win, dq_oe_i);

   always_ff @(posedge clk_400M) begin
      if (rst_i) begin
         err_o <= 1'b0;
      end else if (!(ok_init && ok_mr2 && ok_mr0 && ok_cke && ok_rcd && ok_rp &&
                     ok_rfc && ok_refi && ok_oe)) begin
         err_o <= 1'b1;
      end
   end

   always @(posedge clk_400M) begin
      cyc     <= cyc + 1;
      rst_n_q <= mem_rst_n_i;
      if (!rst_i && is_cmd) begin
         if (init_step < 6) init_step <= init_step + 1;
         case (cmd)
            C_REF: begin
               ref_cyc       <= cyc;
               ref_seen      <= 1'b1;
               act_since_ref <= 1'b0;
            end
            C_ACT: begin
               act_cyc        <= cyc;
               open_row[ba_i] <= a_i[ROW_BITS-1:0];
               act_since_ref  <= 1'b1;
            end
            C_PRE: pre_cyc <= cyc;
            C_WR: begin
               wr_base <= cyc;
               wr_act  <= 1'b1;
               wr_key  <= {ba_i, open_row[ba_i], a_i[COL_BITS-1:0]};
            end
            C_RD: begin
               rd_base <= cyc;
               rd_act  <= 1'b1;
               rd_buf  <= lookup({ba_i, open_row[ba_i], a_i[COL_BITS-1:0]});
            end
            default: ;
         endcase
      end
      if (in_wr_win && dq_oe_i) begin
         wr_buf[(wr_off - CWL) * DQ_BITS +: DQ_BITS] <= dq_i;
         if (wr_off == CWL + BURST_LEN - 1) begin
            mem[wr_key] = {dq_i, wr_buf[BURST_BITS-DQ_BITS-1:0]};
            wr_act <= 1'b0;
         end
      end
   end

   // Read beats start CL cycles after READ is on the pins
   always @(negedge clk_400M) begin
      if (rd_act && rd_off >= CL && rd_off < CL + BURST_LEN) begin
         dq_q <= rd_buf[(rd_off - CL) * DQ_BITS +: DQ_BITS];
      end else begin
         dq_q <= '0;
      end
   end

endmodule

/* tb_ddr3_ctrl.sv */
module tb_ddr3_ctrl;
   timeunit 1ns;
   timeprecision 1ps;
   import ddr3_pkg::*;

   localparam int CL       = 6;
   localparam int CWL      = 5;
   localparam int T_RCD    = 6;
   localparam int T_RP     = 6;
   localparam int T_WR     = 6;
   localparam int T_MRD    = 4;
   localparam int T_MOD    = 12;
   localparam int T_RFC    = 44;
   localparam int T_XPR    = 48;
   localparam int T_ZQINIT = 32;
   localparam int T_PWR    = 4;
   localparam int T_REFI   = 300;
   localparam int N_WR     = 20;

   localparam int ACC_LEN   = T_RCD + CWL + CL + BURST_LEN + T_WR + T_RP + 8;
   localparam int INIT_LEN  = 2 * T_PWR + T_XPR + T_ZQINIT + 4 * T_MRD + T_MOD + T_RFC + 8;
   localparam int IDLE_GAP  = 2 * T_REFI + 120;
   localparam int WD_CYCLES = 8 + INIT_LEN + 2 * N_WR * (ACC_LEN + T_RFC) + IDLE_GAP + 2 * T_REFI;

   logic clk_400M = 1'b0;
   logic rst_i = 1'b1;
   logic read_i = 1'b0;
   logic write_i = 1'b0;
   host_addr_t address_i = '0;
   burst_t write_data_i = '0;
   burst_t read_data_o;
   logic ack_o, busy_o, mem_rst_n_o, cke_o, cs_n_o, ras_n_o, cas_n_o, we_n_o, odt_o;
   bank_t ba_o;
   pin_addr_t a_o;
   logic [DQ_BITS-1:0] dq_o, dq_i;
   logic dq_oe_o, init_ok, model_err;

   logic [31:0] lfsr_q = 32'd66;
   logic        pending = 1'b0;
   logic        cur_wr = 1'b0;
   logic        exp_valid = 1'b0;
   burst_t      exp_data = '0;
   host_addr_t  cur_addr = '0;
   int          acc_cnt = 0;
   int          ack_cnt = 0;
   logic        accept, pin_act, pin_rw;
   burst_t      shadow [host_addr_t];
   host_addr_t  addrs [N_WR];

   ddr3_ctrl_top #(
      .CL(CL), .CWL(CWL), .T_RCD(T_RCD), .T_RP(T_RP), .T_WR(T_WR), .T_MRD(T_MRD),
      .T_MOD(T_MOD), .T_RFC(T_RFC), .T_XPR(T_XPR), .T_ZQINIT(T_ZQINIT),
      .T_PWR(T_PWR), .T_REFI(T_REFI)
   ) dut0 (
      .clk_400M, .rst_i, .read_i, .write_i, .address_i, .write_data_i,
      .read_data_o, .ack_o, .busy_o, .mem_rst_n_o, .cke_o, .cs_n_o, .ras_n_o,
      .cas_n_o, .we_n_o, .ba_o, .a_o, .odt_o, .dq_o, .dq_oe_o, .dq_i
   );

   tb_ddr3_model #(
      .CL(CL), .CWL(CWL), .T_RCD(T_RCD), .T_RP(T_RP), .T_WR(T_WR),
      .T_RFC(T_RFC), .T_REFI(T_REFI), .ACC_LEN(ACC_LEN)
   ) model0 (
      .clk_400M, .rst_i, .mem_rst_n_i(mem_rst_n_o), .cke_i(cke_o), .cs_n_i(cs_n_o),
      .ras_n_i(ras_n_o), .cas_n_i(cas_n_o), .we_n_i(we_n_o), .ba_i(ba_o), .a_i(a_o),
      .dq_i(dq_o), .dq_oe_i(dq_oe_o), .dq_o(dq_i), .init_ok_o(init_ok), .err_o(model_err)
   );

   initial begin
      forever #10 clk_400M = ~clk_400M;
   end

   task automatic fail_run();
      $display("Simulation failed");
      $fatal(1, "Run stopped on first error");
   endtask

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
   endfunction

   task automatic take_bits(input int n, output logic [BURST_BITS-1:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = lfsr_q[0];
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   // Hold the request until ack, then drop it
   task automatic host_access(input logic wr, input host_addr_t addr, input burst_t data,
                              input burst_t exp, input logic chk);
      @(negedge clk_400M);
      cur_addr     = addr;
      exp_data     = exp;
      exp_valid    = chk;
      address_i    = addr;
      write_data_i = data;
      write_i      = wr;
      read_i       = !wr;
      do @(negedge clk_400M); while (!ack_o);
      write_i = 1'b0;
      read_i  = 1'b0;
   endtask

   assign accept  = !busy_o && (write_i || read_i);
   assign pin_act = !cs_n_o && {ras_n_o, cas_n_o, we_n_o} == 3'b011;
   assign pin_rw  = !cs_n_o && {ras_n_o, cas_n_o} == 2'b10;

   always_ff @(posedge clk_400M) begin
      if (rst_i) begin
         pending <= 1'b0;
      end else begin
         if (accept) begin
            pending <= 1'b1;
            cur_wr  <= write_i;
            acc_cnt <= acc_cnt + 1;
         end else if (ack_o) begin
            pending <= 1'b0;
            ack_cnt <= ack_cnt + 1;
         end
      end
   end

   a_ack_req: assert property (@(posedge clk_400M) disable iff (rst_i) ack_o |-> pending)
      else begin
         $display("ack_o pulsed with no accepted request in flight");
         fail_run();
      end
   a_one_flight: assert property (@(posedge clk_400M) disable iff (rst_i) accept |-> !pending)
      else begin
         $display("Request accepted while another access was in flight");
         fail_run();
      end
   a_busy_held: assert property (@(posedge clk_400M) disable iff (rst_i) pending |-> busy_o)
      else begin
         $display("Mismatch at %0t: busy_o expected 1 got 0", $time);
         fail_run();
      end
   a_init_busy: assert property (@(posedge clk_400M) disable iff (rst_i) !busy_o |-> init_ok)
      else begin
         $display("busy_o fell before initialization and first refresh");
         fail_run();
      end
   a_odt: assert property (@(posedge clk_400M) disable iff (rst_i)
      odt_o == (pending && cur_wr))
      else begin
         $display("Mismatch at %0t: odt_o expected %b got %b", $time, pending && cur_wr, odt_o);
         fail_run();
      end
   a_act_after_accept: assert property (@(posedge clk_400M) disable iff (rst_i)
      pin_act |-> $past(accept, 2))
      else begin
         $display("ACT on the pins without an accepted request");
         fail_run();
      end
   a_act_addr: assert property (@(posedge clk_400M) disable iff (rst_i)
      pin_act |-> (ba_o == cur_addr[HOST_BITS-1 -: BA_BITS] &&
                   a_o == pin_addr_t'(cur_addr[COL_BITS +: ROW_BITS])))
      else begin
         $display("Mismatch at %0t: ACT bank/row expected %h got %h/%h", $time,
                  cur_addr[HOST_BITS-1:COL_BITS], ba_o, a_o);
         fail_run();
      end
   a_col_addr: assert property (@(posedge clk_400M) disable iff (rst_i)
      pin_rw |-> a_o == pin_addr_t'(cur_addr[COL_BITS-1:0]))
      else begin
         $display("Mismatch at %0t: a_o expected %h got %h", $time,
                  pin_addr_t'(cur_addr[COL_BITS-1:0]), a_o);
         fail_run();
      end
   a_read_data: assert property (@(posedge clk_400M) disable iff (rst_i)
      (ack_o && exp_valid) |-> read_data_o == exp_data)
      else begin
         $display("Mismatch at %0t: read_data_o expected %h got %h", $time, exp_data, read_data_o);
         fail_run();
      end
   a_model: assert property (@(posedge clk_400M) disable iff (rst_i) !model_err)
      else fail_run();

   initial begin
      repeat (WD_CYCLES) @(posedge clk_400M);
      $display("Timeout after %0d cycles with %0d acks", WD_CYCLES, ack_cnt);
      fail_run();
   end

   initial begin
      logic [BURST_BITS-1:0] v, d;
      host_addr_t tmp;
      int j;
      repeat (8) @(posedge clk_400M);
      @(negedge clk_400M);
      rst_i = 1'b0;
      for (int i = 0; i < N_WR; i++) begin
         take_bits(HOST_BITS, v);
         take_bits(BURST_BITS, d);
         addrs[i] = host_addr_t'(v);
         shadow[addrs[i]] = d;
         host_access(1'b1, addrs[i], d, '0, 1'b0);
      end
      for (int i = N_WR - 1; i > 0; i--) begin // Shuffle the read order
         take_bits(8, v);
         j = int'(v[7:0]) % (i + 1);
         tmp = addrs[i];
         addrs[i] = addrs[j];
         addrs[j] = tmp;
      end
      for (int i = 0; i < N_WR; i++) begin
         host_access(1'b0, addrs[i], '0, shadow[addrs[i]], 1'b1);
      end
      repeat (IDLE_GAP) @(negedge clk_400M); // Idle refreshes only
      if (pending || acc_cnt != 2 * N_WR || ack_cnt != acc_cnt) begin
         $display("Host count wrong: %0d accepted, %0d acked", acc_cnt, ack_cnt);
         fail_run();
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

/* project.f */
ddr3_pkg.sv
ddr3_init_seq.sv
ddr3_access_fsm.sv
ddr3_cmd_encoder.sv
ddr3_write_path.sv
ddr3_read_path.sv
ddr3_ctrl_top.sv
tb_ddr3_model.sv
tb_ddr3_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DDR3 sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_ddr3_ctrl -o tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
   echo "Result: pass"
   exit 0
fi

echo "Result: fail (simulator status $sim_status)"
exit 1
